//--- cache_defs.svh
// cache geometry macros, included by every file that sizes a port or an array
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address split: tag | index | offset
`define CACHE_TAG_WIDTH 8
`define CACHE_INDEX_WIDTH 3
`define CACHE_OFFSET_WIDTH 2

// one data word per offset
`define CACHE_DATA_WIDTH 32

// way number width, also the width of an lru age
`define CACHE_WAY_WIDTH 2

// derived counts
`define CACHE_SETS (1 << `CACHE_INDEX_WIDTH)
`define CACHE_WORDS (1 << `CACHE_OFFSET_WIDTH)
`define CACHE_WAYS (1 << `CACHE_WAY_WIDTH)

`endif

//--- CachePkg.sv
// coherence state type shared by the cache rtl and its testbench, referenced by scoped name
package CachePkg;

	// line states of a snooping protocol
	// only invalid has a meaning inside the array, the others are stored as given
	typedef enum logic [1 : 0] {
		invalid   = 2'b00,
		shared    = 2'b01,
		exclusive = 2'b10,
		modified  = 2'b11
	} CoherenceState;

endpackage : CachePkg

//--- DirectMappingCacheUnit.sv
// one way of the set-associative cache, with a cpu lookup/write port and a snoop port
`timescale 1ns/1ps
`include "cache_defs.svh"

module DirectMappingCacheUnit #(
	type StateType = CachePkg::CoherenceState,
	parameter StateType invalidState = CachePkg::invalid
)(
	input  logic                                clock,
	input  logic                                reset,

	// cpu side
	input  logic [`CACHE_INDEX_WIDTH - 1 : 0]   cpuIndex,
	input  logic [`CACHE_OFFSET_WIDTH - 1 : 0]  cpuOffset,
	input  logic [`CACHE_TAG_WIDTH - 1 : 0]     cpuTagIn,
	input  logic [`CACHE_DATA_WIDTH - 1 : 0]    cpuDataIn,
	input  StateType                            cpuStateIn,
	input  logic                                cpuWriteTag,
	input  logic                                cpuWriteData,
	input  logic                                cpuWriteState,
	output logic                                cpuHit,
	output logic [`CACHE_TAG_WIDTH - 1 : 0]     cpuTagOut,
	output logic [`CACHE_DATA_WIDTH - 1 : 0]    cpuDataOut,
	output StateType                            cpuStateOut,

	// snoop side
	input  logic [`CACHE_INDEX_WIDTH - 1 : 0]   snoopyIndex,
	input  logic [`CACHE_TAG_WIDTH - 1 : 0]     snoopyTagIn,
	input  StateType                            snoopyStateIn,
	input  logic                                snoopyWriteState,
	output logic                                snoopyHit,
	output StateType                            snoopyStateOut
);

	// per-set storage
	logic [`CACHE_TAG_WIDTH - 1 : 0]  tagArray   [`CACHE_SETS];
	StateType                         stateArray [`CACHE_SETS];
	logic [`CACHE_DATA_WIDTH - 1 : 0] dataArray  [`CACHE_SETS][`CACHE_WORDS];

	logic cpuValid;
	logic snoopyValid;

	// cpu lookup
	assign cpuValid    = (stateArray[cpuIndex] != invalidState);
	assign cpuHit      = cpuValid && (tagArray[cpuIndex] == cpuTagIn);
	assign cpuTagOut   = tagArray[cpuIndex];
	assign cpuDataOut  = dataArray[cpuIndex][cpuOffset];
	assign cpuStateOut = stateArray[cpuIndex];

	// snoop lookup, state only
	assign snoopyValid    = (stateArray[snoopyIndex] != invalidState);
	assign snoopyHit      = snoopyValid && (tagArray[snoopyIndex] == snoopyTagIn);
	assign snoopyStateOut = stateArray[snoopyIndex];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				tagArray[s]   <= '0;
				stateArray[s] <= invalidState;
				for (int o = 0; o < `CACHE_WORDS; o++) begin
					dataArray[s][o] <= '0;
				end
			end
		end else begin
			if (cpuWriteTag) begin
				tagArray[cpuIndex] <= cpuTagIn;
			end
			// only the addressed word of the line
			if (cpuWriteData) begin
				dataArray[cpuIndex][cpuOffset] <= cpuDataIn;
			end
			if (cpuWriteState) begin
				stateArray[cpuIndex] <= cpuStateIn;
			end
			// snoop write comes last, so it wins when both hit the same set
			if (snoopyWriteState) begin
				stateArray[snoopyIndex] <= snoopyStateIn;
			end
		end
	end

endmodule : DirectMappingCacheUnit

//--- SetAssociativeLRU.sv
// per-set lru ages for the cache ways, gives the replacement way for the cpu set
`timescale 1ns/1ps
`include "cache_defs.svh"

module SetAssociativeLRU (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [`CACHE_INDEX_WIDTH - 1 : 0] cpuIndex,
	input  logic [`CACHE_WAY_WIDTH - 1 : 0]   accessWay,
	input  logic                              accessEnable,
	input  logic [`CACHE_INDEX_WIDTH - 1 : 0] snoopyIndex,
	input  logic [`CACHE_WAY_WIDTH - 1 : 0]   invalidateWay,
	input  logic                              invalidateEnable,
	output logic [`CACHE_WAY_WIDTH - 1 : 0]   replacementWay
);

	// age 0 is the oldest way, all ones the newest
	localparam logic [`CACHE_WAY_WIDTH - 1 : 0] oldestAge = '0;
	localparam logic [`CACHE_WAY_WIDTH - 1 : 0] newestAge = '1;

	logic [`CACHE_WAY_WIDTH - 1 : 0] ages     [`CACHE_SETS][`CACHE_WAYS];
	logic [`CACHE_WAY_WIDTH - 1 : 0] nextAges [`CACHE_SETS][`CACHE_WAYS];
	logic [`CACHE_WAY_WIDTH - 1 : 0] accessAge;
	logic [`CACHE_WAY_WIDTH - 1 : 0] invalidateAge;

	// access is applied first, the invalidate then sees its result
	always_comb begin
		nextAges      = ages;
		accessAge     = nextAges[cpuIndex][accessWay];
		if (accessEnable) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (nextAges[cpuIndex][w] > accessAge) begin
					nextAges[cpuIndex][w] = nextAges[cpuIndex][w] - 1'b1;
				end
			end
			nextAges[cpuIndex][accessWay] = newestAge;
		end
		invalidateAge = nextAges[snoopyIndex][invalidateWay];
		if (invalidateEnable) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (nextAges[snoopyIndex][w] < invalidateAge) begin
					nextAges[snoopyIndex][w] = nextAges[snoopyIndex][w] + 1'b1;
				end
			end
			nextAges[snoopyIndex][invalidateWay] = oldestAge;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// way 0 oldest up to the last way newest
			for (int s = 0; s < `CACHE_SETS; s++) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					ages[s][w] <= w[`CACHE_WAY_WIDTH - 1 : 0];
				end
			end
		end else begin
			ages <= nextAges;
		end
	end

	// ages in a set are a permutation, so exactly one way is oldest
	always_comb begin
		replacementWay = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (ages[cpuIndex][w] == oldestAge) begin
				replacementWay = w[`CACHE_WAY_WIDTH - 1 : 0];
			end
		end
	end

endmodule : SetAssociativeLRU

//--- SetAssociativeCache.sv
// top of the snooping set-associative cache array, ways plus lru with hit and write steering
`timescale 1ns/1ps
`include "cache_defs.svh"

module SetAssociativeCache #(
	type StateType = CachePkg::CoherenceState,
	parameter StateType invalidState = CachePkg::invalid
)(
	input  logic                                clock,
	input  logic                                reset,

	// cpu port
	input  logic [`CACHE_INDEX_WIDTH - 1 : 0]   cpuIndex,
	input  logic [`CACHE_OFFSET_WIDTH - 1 : 0]  cpuOffset,
	input  logic [`CACHE_TAG_WIDTH - 1 : 0]     cpuTagIn,
	input  logic [`CACHE_DATA_WIDTH - 1 : 0]    cpuDataIn,
	input  StateType                            cpuStateIn,
	input  logic                                cpuWriteTag,
	input  logic                                cpuWriteData,
	input  logic                                cpuWriteState,
	input  logic                                accessEnable,
	output logic                                cpuHit,
	output logic [`CACHE_WAY_WIDTH - 1 : 0]     cpuWay,
	output logic [`CACHE_TAG_WIDTH - 1 : 0]     cpuTagOut,
	output logic [`CACHE_DATA_WIDTH - 1 : 0]    cpuDataOut,
	output StateType                            cpuStateOut,

	// snoop port
	input  logic [`CACHE_INDEX_WIDTH - 1 : 0]   snoopyIndex,
	input  logic [`CACHE_TAG_WIDTH - 1 : 0]     snoopyTagIn,
	input  StateType                            snoopyStateIn,
	input  logic                                snoopyWriteState,
	input  logic                                invalidateEnable,
	output logic                                snoopyHit,
	output logic [`CACHE_WAY_WIDTH - 1 : 0]     snoopyWay,
	output StateType                            snoopyStateOut
);

	// per-way hits and write enables
	logic [`CACHE_WAYS - 1 : 0] cpuWayHits;
	logic [`CACHE_WAYS - 1 : 0] snoopyWayHits;
	logic [`CACHE_WAYS - 1 : 0] cpuWaySelect;
	logic [`CACHE_WAYS - 1 : 0] cpuWayWriteTag;
	logic [`CACHE_WAYS - 1 : 0] cpuWayWriteData;
	logic [`CACHE_WAYS - 1 : 0] cpuWayWriteState;
	logic [`CACHE_WAYS - 1 : 0] snoopyWayWriteState;

	// per-way lookup results
	logic [`CACHE_TAG_WIDTH - 1 : 0]  wayTagOut  [`CACHE_WAYS];
	logic [`CACHE_DATA_WIDTH - 1 : 0] wayDataOut [`CACHE_WAYS];
	StateType                         wayCpuStateOut    [`CACHE_WAYS];
	StateType                         waySnoopyStateOut [`CACHE_WAYS];

	logic [`CACHE_WAY_WIDTH - 1 : 0] cpuHitWay;
	logic [`CACHE_WAY_WIDTH - 1 : 0] replacementWay;

	genvar i;
	generate
		for (i = 0; i < `CACHE_WAYS; i++) begin : wayGen
			DirectMappingCacheUnit #(
				.StateType(StateType),
				.invalidState(invalidState)
			) wayUnit (
				.clock(clock),
				.reset(reset),
				.cpuIndex(cpuIndex),
				.cpuOffset(cpuOffset),
				.cpuTagIn(cpuTagIn),
				.cpuDataIn(cpuDataIn),
				.cpuStateIn(cpuStateIn),
				.cpuWriteTag(cpuWayWriteTag[i]),
				.cpuWriteData(cpuWayWriteData[i]),
				.cpuWriteState(cpuWayWriteState[i]),
				.cpuHit(cpuWayHits[i]),
				.cpuTagOut(wayTagOut[i]),
				.cpuDataOut(wayDataOut[i]),
				.cpuStateOut(wayCpuStateOut[i]),
				.snoopyIndex(snoopyIndex),
				.snoopyTagIn(snoopyTagIn),
				.snoopyStateIn(snoopyStateIn),
				.snoopyWriteState(snoopyWayWriteState[i]),
				.snoopyHit(snoopyWayHits[i]),
				.snoopyStateOut(waySnoopyStateOut[i])
			);

			// cpu writes follow the selected way, snoop writes only the hit way
			assign cpuWayWriteTag[i]      = cpuWriteTag && cpuWaySelect[i];
			assign cpuWayWriteData[i]     = cpuWriteData && cpuWaySelect[i];
			assign cpuWayWriteState[i]    = cpuWriteState && cpuWaySelect[i];
			assign snoopyWayWriteState[i] = snoopyWriteState && snoopyWayHits[i];
		end
	endgenerate

	SetAssociativeLRU lru (
		.clock(clock),
		.reset(reset),
		.cpuIndex(cpuIndex),
		.accessWay(cpuWay),
		.accessEnable(accessEnable),
		.snoopyIndex(snoopyIndex),
		.invalidateWay(snoopyWay),
		.invalidateEnable(invalidateEnable && snoopyHit),
		.replacementWay(replacementWay)
	);

	assign cpuHit    = |cpuWayHits;
	assign snoopyHit = |snoopyWayHits;

	// hit encoders, way 0 when nothing hits
	always_comb begin
		cpuHitWay  = '0;
		snoopyWay  = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (cpuWayHits[w]) begin
				cpuHitWay = w[`CACHE_WAY_WIDTH - 1 : 0];
			end
			if (snoopyWayHits[w]) begin
				snoopyWay = w[`CACHE_WAY_WIDTH - 1 : 0];
			end
		end
	end

	// on a miss the victim from the lru is used
	assign cpuWay = cpuHit ? cpuHitWay : replacementWay;

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			cpuWaySelect[w] = (cpuWay == w[`CACHE_WAY_WIDTH - 1 : 0]);
		end
	end

	// output muxes, on a cpu miss these show the victim line
	assign cpuTagOut      = wayTagOut[cpuWay];
	assign cpuDataOut     = wayDataOut[cpuWay];
	assign cpuStateOut    = wayCpuStateOut[cpuWay];
	assign snoopyStateOut = waySnoopyStateOut[snoopyWay];

endmodule : SetAssociativeCache

//--- SetAssociativeCache_chk.sv
// assertions on the cache top level hit and write vectors, bound into SetAssociativeCache
`timescale 1ns/1ps
`include "cache_defs.svh"

module SetAssociativeCacheChk (
	input logic                       clock,
	input logic                       reset,
	input logic                       cpuHit,
	input logic                       snoopyHit,
	input logic [`CACHE_WAYS - 1 : 0] cpuWayHits,
	input logic [`CACHE_WAYS - 1 : 0] snoopyWayHits,
	input logic [`CACHE_WAYS - 1 : 0] cpuWayWriteTag,
	input logic [`CACHE_WAYS - 1 : 0] cpuWayWriteData,
	input logic [`CACHE_WAYS - 1 : 0] cpuWayWriteState
);

	// a valid tag sits in at most one way of a set
	cpuHitsOneHot: assert property (@(posedge clock) disable iff (reset) $onehot0(cpuWayHits))
		else $error("more than one way reports a cpu hit");
	snoopyHitsOneHot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(snoopyWayHits))
		else $error("more than one way reports a snoop hit");

	// all lines are invalid right after reset
	noHitAfterReset: assert property (@(posedge clock) $fell(reset) |-> !cpuHit && !snoopyHit)
		else $error("a lookup hit in the first cycle after reset");

	// cpu writes reach only the selected way
	cpuWriteOneWay: assert property (@(posedge clock) disable iff (reset)
		$onehot0(cpuWayWriteTag | cpuWayWriteData | cpuWayWriteState))
		else $error("cpu write enables active in more than one way");

endmodule : SetAssociativeCacheChk

bind SetAssociativeCache SetAssociativeCacheChk chk_i (
	.clock(clock),
	.reset(reset),
	.cpuHit(cpuHit),
	.snoopyHit(snoopyHit),
	.cpuWayHits(cpuWayHits),
	.snoopyWayHits(snoopyWayHits),
	.cpuWayWriteTag(cpuWayWriteTag),
	.cpuWayWriteData(cpuWayWriteData),
	.cpuWayWriteState(cpuWayWriteState)
);

//--- SetAssociativeCacheTb.sv
// directed testbench for the set-associative cache that checks every output against a line and lru model
`timescale 1ns/1ps
`include "cache_defs.svh"

module SetAssociativeCacheTb;

	// reset and tests take about 180 cycles and the limit leaves about twice that
	localparam int timeoutCycles = 400;
	localparam int randomCycles  = 150;

	logic                               clock;
	logic                               reset;
	logic [`CACHE_INDEX_WIDTH - 1 : 0]  cpuIndex;
	logic [`CACHE_OFFSET_WIDTH - 1 : 0] cpuOffset;
	logic [`CACHE_TAG_WIDTH - 1 : 0]    cpuTagIn;
	logic [`CACHE_DATA_WIDTH - 1 : 0]   cpuDataIn;
	CachePkg::CoherenceState            cpuStateIn;
	logic                               cpuWriteTag;
	logic                               cpuWriteData;
	logic                               cpuWriteState;
	logic                               accessEnable;
	logic                               cpuHit;
	logic [`CACHE_WAY_WIDTH - 1 : 0]    cpuWay;
	logic [`CACHE_TAG_WIDTH - 1 : 0]    cpuTagOut;
	logic [`CACHE_DATA_WIDTH - 1 : 0]   cpuDataOut;
	CachePkg::CoherenceState            cpuStateOut;
	logic [`CACHE_INDEX_WIDTH - 1 : 0]  snoopyIndex;
	logic [`CACHE_TAG_WIDTH - 1 : 0]    snoopyTagIn;
	CachePkg::CoherenceState            snoopyStateIn;
	logic                               snoopyWriteState;
	logic                               invalidateEnable;
	logic                               snoopyHit;
	logic [`CACHE_WAY_WIDTH - 1 : 0]    snoopyWay;
	CachePkg::CoherenceState            snoopyStateOut;

	// reference model indexed way first like the hardware ways
	logic [`CACHE_TAG_WIDTH - 1 : 0]  modelTag   [`CACHE_WAYS][`CACHE_SETS];
	CachePkg::CoherenceState          modelState [`CACHE_WAYS][`CACHE_SETS];
	logic [`CACHE_DATA_WIDTH - 1 : 0] modelData  [`CACHE_WAYS][`CACHE_SETS][`CACHE_WORDS];
	int                               modelAge   [`CACHE_SETS][`CACHE_WAYS];

	logic [31 : 0] rngState;
	logic [31 : 0] lineBase;
	string         testName;
	int            cycleCount = 0;

	SetAssociativeCache dut_i (.*);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: the run did not finish within %0d clock cycles", timeoutCycles);
			$display("STATUS: FAIL");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	function automatic logic [31 : 0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic checkValue(string what, logic [31 : 0] expected, logic [31 : 0] actual);
		if (expected !== actual) begin
			$display("mismatch in %s: %s expected 0x%0h actual 0x%0h",
				testName, what, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "output check failed");
		end
	endtask

	// way holding a valid copy of tag or -1 when none does
	function automatic int findWay(int set, logic [`CACHE_TAG_WIDTH - 1 : 0] tag);
		int found;
		found = -1;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (modelState[w][set] != CachePkg::invalid && modelTag[w][set] == tag) begin
				found = w;
			end
		end
		return found;
	endfunction

	function automatic int oldestWay(int set);
		int oldest;
		oldest = 0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (modelAge[set][w] == 0) begin
				oldest = w;
			end
		end
		return oldest;
	endfunction

	// an access makes the way newest and an invalidate makes it oldest
	task automatic moveAge(int set, int way, logic toNewest);
		int old;
		old = modelAge[set][way];
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (toNewest && modelAge[set][w] > old) begin
				modelAge[set][w]--;
			end else if (!toNewest && modelAge[set][w] < old) begin
				modelAge[set][w]++;
			end
		end
		modelAge[set][way] = toNewest ? `CACHE_WAYS - 1 : 0;
	endtask

	task automatic resetModel();
		for (int s = 0; s < `CACHE_SETS; s++) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				modelTag[w][s]   = '0;
				modelState[w][s] = CachePkg::invalid;
				modelAge[s][w]   = w;
				for (int o = 0; o < `CACHE_WORDS; o++) begin
					modelData[w][s][o] = '0;
				end
			end
		end
	endtask

	task automatic clearInputs();
		cpuIndex         = '0;
		cpuOffset        = '0;
		cpuTagIn         = '0;
		cpuDataIn        = '0;
		cpuStateIn       = CachePkg::invalid;
		cpuWriteTag      = 1'b0;
		cpuWriteData     = 1'b0;
		cpuWriteState    = 1'b0;
		accessEnable     = 1'b0;
		snoopyIndex      = '0;
		snoopyTagIn      = '0;
		snoopyStateIn    = CachePkg::invalid;
		snoopyWriteState = 1'b0;
		invalidateEnable = 1'b0;
	endtask

	task automatic startCycle();
		@(negedge clock);
		clearInputs();
	endtask

	task automatic setCpu(int set, logic [31 : 0] tag, int offset, logic access);
		cpuIndex     = set[`CACHE_INDEX_WIDTH - 1 : 0];
		cpuTagIn     = tag[`CACHE_TAG_WIDTH - 1 : 0];
		cpuOffset    = offset[`CACHE_OFFSET_WIDTH - 1 : 0];
		accessEnable = access;
	endtask

	task automatic setFill(logic [31 : 0] data, CachePkg::CoherenceState state);
		cpuWriteTag   = 1'b1;
		cpuWriteData  = 1'b1;
		cpuWriteState = 1'b1;
		cpuDataIn     = data;
		cpuStateIn    = state;
	endtask

	task automatic setSnoop(int set, logic [31 : 0] tag, CachePkg::CoherenceState state,
		logic write, logic invalidate);
		snoopyIndex      = set[`CACHE_INDEX_WIDTH - 1 : 0];
		snoopyTagIn      = tag[`CACHE_TAG_WIDTH - 1 : 0];
		snoopyStateIn    = state;
		snoopyWriteState = write;
		invalidateEnable = invalidate;
	endtask

	// sample mid low phase and then advance the model to the next rising edge
	task automatic stepAndCheck();
		int cpuHitWay;
		int snoopHitWay;
		int expCpuWay;
		int expSnoopWay;
		#10;
		cpuHitWay   = findWay(int'(cpuIndex), cpuTagIn);
		snoopHitWay = findWay(int'(snoopyIndex), snoopyTagIn);
		expCpuWay   = (cpuHitWay >= 0) ? cpuHitWay : oldestWay(int'(cpuIndex));
		expSnoopWay = (snoopHitWay >= 0) ? snoopHitWay : 0;
		checkValue("cpuHit", 32'(cpuHitWay >= 0), 32'(cpuHit));
		checkValue("cpuWay", expCpuWay, 32'(cpuWay));
		checkValue("cpuTagOut", 32'(modelTag[expCpuWay][cpuIndex]), 32'(cpuTagOut));
		checkValue("cpuDataOut", modelData[expCpuWay][cpuIndex][cpuOffset], cpuDataOut);
		checkValue("cpuStateOut", 32'(modelState[expCpuWay][cpuIndex]), 32'(cpuStateOut));
		checkValue("snoopyHit", 32'(snoopHitWay >= 0), 32'(snoopyHit));
		checkValue("snoopyWay", expSnoopWay, 32'(snoopyWay));
		checkValue("snoopyStateOut", 32'(modelState[expSnoopWay][snoopyIndex]),
			32'(snoopyStateOut));
		if (cpuWriteTag) begin
			modelTag[expCpuWay][cpuIndex] = cpuTagIn;
		end
		if (cpuWriteData) begin
			modelData[expCpuWay][cpuIndex][cpuOffset] = cpuDataIn;
		end
		if (cpuWriteState) begin
			modelState[expCpuWay][cpuIndex] = cpuStateIn;
		end
		// applied after the cpu write so it wins on the same line
		if (snoopyWriteState && snoopHitWay >= 0) begin
			modelState[snoopHitWay][snoopyIndex] = snoopyStateIn;
		end
		if (accessEnable) begin
			moveAge(int'(cpuIndex), expCpuWay, 1'b1);
		end
		if (invalidateEnable && snoopHitWay >= 0) begin
			moveAge(int'(snoopyIndex), snoopHitWay, 1'b0);
		end
	endtask

	task automatic resetLookupTest();
		testName = "resetLookup";
		for (int s = 0; s < `CACHE_SETS; s++) begin
			startCycle();
			setCpu(s, nextRandom(), 0, 1'b0);
			setSnoop(`CACHE_SETS - 1 - s, nextRandom(), CachePkg::invalid, 1'b0, 1'b0);
			stepAndCheck();
			checkValue("cpuHit", 0, 32'(cpuHit));
			checkValue("cpuWay", 0, 32'(cpuWay));
		end
	endtask

	task automatic fillReadTest();
		logic [31 : 0] tag;
		logic [31 : 0] word0;
		logic [31 : 0] word3;
		testName = "fillRead";
		tag   = nextRandom();
		word0 = nextRandom();
		word3 = nextRandom();
		// miss fill of word 0 and then word 3 goes into the now hitting line
		startCycle();
		setCpu(2, tag, 0, 1'b1);
		setFill(word0, CachePkg::exclusive);
		stepAndCheck();
		startCycle();
		setCpu(2, tag, 3, 1'b0);
		cpuWriteData = 1'b1;
		cpuDataIn    = word3;
		stepAndCheck();
		checkValue("cpuHit", 1, 32'(cpuHit));
		startCycle();
		setCpu(2, tag, 0, 1'b0);
		stepAndCheck();
		checkValue("cpuWay", 0, 32'(cpuWay));
		checkValue("cpuDataOut", word0, cpuDataOut);
		checkValue("cpuStateOut", 32'(CachePkg::exclusive), 32'(cpuStateOut));
		startCycle();
		setCpu(2, tag, 3, 1'b0);
		stepAndCheck();
		checkValue("cpuDataOut", word3, cpuDataOut);
	endtask

	task automatic replacementTest();
		testName = "replacement";
		lineBase = nextRandom();
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			startCycle();
			setCpu(5, lineBase + w, w, 1'b1);
			setFill(nextRandom(), CachePkg::shared);
			stepAndCheck();
			checkValue("cpuWay", w, 32'(cpuWay));
		end
		// a new tag picks way 0 and after touching way 0 it picks way 1
		startCycle();
		setCpu(5, lineBase + 4, 0, 1'b0);
		stepAndCheck();
		checkValue("cpuWay", 0, 32'(cpuWay));
		startCycle();
		setCpu(5, lineBase, 0, 1'b1);
		stepAndCheck();
		startCycle();
		setCpu(5, lineBase + 4, 0, 1'b0);
		stepAndCheck();
		checkValue("cpuWay", 1, 32'(cpuWay));
	endtask

	task automatic snoopStateTest();
		testName = "snoopState";
		startCycle();
		setSnoop(5, lineBase + 2, CachePkg::invalid, 1'b0, 1'b0);
		stepAndCheck();
		checkValue("snoopyHit", 1, 32'(snoopyHit));
		checkValue("snoopyWay", 2, 32'(snoopyWay));
		checkValue("snoopyStateOut", 32'(CachePkg::shared), 32'(snoopyStateOut));
		// both ports write this line's state in one cycle
		startCycle();
		setCpu(5, lineBase + 2, 0, 1'b0);
		cpuWriteState = 1'b1;
		cpuStateIn    = CachePkg::exclusive;
		setSnoop(5, lineBase + 2, CachePkg::modified, 1'b1, 1'b0);
		stepAndCheck();
		startCycle();
		setCpu(5, lineBase + 2, 0, 1'b0);
		stepAndCheck();
		checkValue("cpuStateOut", 32'(CachePkg::modified), 32'(cpuStateOut));
	endtask

	task automatic invalidateTest();
		testName = "invalidate";
		startCycle();
		setSnoop(5, lineBase + 2, CachePkg::invalid, 1'b1, 1'b1);
		stepAndCheck();
		startCycle();
		setCpu(5, lineBase + 2, 0, 1'b0);
		stepAndCheck();
		checkValue("cpuHit", 0, 32'(cpuHit));
		// freed way 2 is now the oldest in set 5
		checkValue("cpuWay", 2, 32'(cpuWay));
	endtask

	task automatic randomMixTest();
		int cpuOp;
		int snoopOp;
		int set;
		int way;
		testName = "randomMix";
		for (int n = 0; n < randomCycles; n++) begin
			startCycle();
			cpuOp = int'(nextRandom() % 3);
			set   = int'(nextRandom() % `CACHE_SETS);
			way   = int'(nextRandom() % `CACHE_WAYS);
			// 0 fills a random tag, 1 writes a word of a stored tag, 2 only looks up
			if (cpuOp == 0) begin
				setCpu(set, nextRandom(), int'(nextRandom() % `CACHE_WORDS), 1'b1);
				setFill(nextRandom(), CachePkg::CoherenceState'(1 + nextRandom() % 3));
			end else begin
				setCpu(set, 32'(modelTag[way][set]), int'(nextRandom() % `CACHE_WORDS),
					cpuOp == 1);
				cpuWriteData = (cpuOp == 1);
				cpuDataIn    = nextRandom();
			end
			snoopOp = int'(nextRandom() % 3);
			set     = int'(nextRandom() % `CACHE_SETS);
			way     = int'(nextRandom() % `CACHE_WAYS);
			// 0 invalidates, 1 downgrades to shared, 2 only looks up
			setSnoop(set, 32'(modelTag[way][set]),
				snoopOp == 0 ? CachePkg::invalid : CachePkg::shared, snoopOp < 2, snoopOp == 0);
			stepAndCheck();
		end
	endtask

	initial begin
		clock      = 1'b0;
		reset      = 1'b1;
		rngState   = 32'd92;
		testName   = "reset";
		clearInputs();
		resetModel();
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		resetLookupTest();
		fillReadTest();
		replacementTest();
		snoopStateTest();
		invalidateTest();
		randomMixTest();
		$display("STATUS: PASS");
		$finish;
	end

endmodule : SetAssociativeCacheTb

//--- filelist.f
+incdir+.
CachePkg.sv
DirectMappingCacheUnit.sv
SetAssociativeLRU.sv
SetAssociativeCache.sv
SetAssociativeCache_chk.sv
SetAssociativeCacheTb.sv

//--- Makefile
TOP = SetAssociativeCacheTb

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f filelist.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -Wall \
		--top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
